// File: Bender.yml
package:
  name: lsu

sources:
  - files:
      - verilog/lsu_pkg.sv
      - verilog/store_buffer.sv
      - verilog/load_unit.sv
      - verilog/mem_arbiter.sv
      - verilog/data_mem.sv
      - verilog/lsu_top.sv
  - target: test
    files:
      - tb/lsu_properties.sv
      - tb/tb_lsu_top.sv

// File: files.f
verilog/lsu_pkg.sv
verilog/store_buffer.sv
verilog/load_unit.sv
verilog/mem_arbiter.sv
verilog/data_mem.sv
verilog/lsu_top.sv
tb/lsu_properties.sv
tb/tb_lsu_top.sv

// File: tb/lsu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_properties import lsu_pkg::*; #(
    parameter int sb_size = 4
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     store_stall,
    input mem_req_t                 drain_req,
    input logic [$clog2(sb_size):0] head_q,
    input logic [$clog2(sb_size):0] tail_q,
    input logic [sb_size-1:0]       committed_q
);

    localparam int ptr_w = $clog2(sb_size);

    int             fail_cnt = 0;             // Summed into the final count
    logic [ptr_w:0] count;

    assign count = tail_q - head_q;           // Wraps past sb_size if head overtakes tail

    // Full means tail is one lap ahead of head, same slot and other wrap bit
    stall_needs_full: assert property (@(posedge clk) disable iff (reset)
        store_stall |-> tail_q == {~head_q[ptr_w], head_q[ptr_w-1:0]})
        else begin
            $error("store_stall high while the store buffer has a free entry");
            fail_cnt++;
        end

    // Only the committed head entry may go to memory
    drain_committed: assert property (@(posedge clk) disable iff (reset)
        drain_req.en |-> committed_q[head_q[ptr_w-1:0]])
        else begin
            $error("drain requested for an uncommitted head entry");
            fail_cnt++;
        end

    head_not_past_tail: assert property (@(posedge clk) disable iff (reset)
        count <= (ptr_w+1)'(sb_size))
        else begin
            $error("store buffer head pointer moved past the tail");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: tb/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top import lsu_pkg::*; ();

    localparam int sb_size     = 4;
    localparam int mem_words   = 256;
    localparam int n_words     = 8;         // Small window so loads hit buffered stores
    localparam int n_random    = 600;
    localparam int cycle_limit = 40 * (n_random + 40);

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 store_valid;
    store_req_t           store;
    logic                 store_stall;
    logic                 complete;
    logic [rob_idx_w-1:0] complete_idx;
    logic                 exception;
    logic                 load_valid;
    logic [xlen-1:0]      load_addr;
    logic                 load_busy;
    logic                 load_done;
    logic [xlen-1:0]      load_data;

    logic [31:0]          rng = 32'h41e6_36d2;
    logic [xlen-1:0]      model_mem [n_words];  // Memory after in-order retire
    store_req_t           sq [$];               // Stores in flight, oldest first
    bit                   cq [$];               // Committed flag per queued store
    logic [rob_idx_w-1:0] rob_ctr;
    bit                   saw_stall;
    int                   cyc = 0;
    int                   checks = 0;
    int                   errors = 0;
    int                   test_errs = 0;
    int                   tests = 0;

    lsu_top #(.sb_size(sb_size), .mem_words(mem_words)) lsu_top_i (.*);

    bind store_buffer lsu_properties #(.sb_size(sb_size)) lsu_properties_i (
        .clk, .reset, .store_stall, .drain_req, .head_q, .tail_q, .committed_q
    );

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cyc);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    // One store laid over a word, lanes picked by size and low address bits
    function automatic logic [xlen-1:0] apply_store(logic [xlen-1:0] old, store_req_t s);
        logic [xlen-1:0] v;
        v = old;
        case (s.funct3)
            f3_sb:   v[8*s.addr[1:0] +: 8] = s.data[7:0];
            f3_sh:   v[16*s.addr[1] +: 16] = s.data[15:0];
            default: v = s.data;
        endcase
        return v;
    endfunction

    function automatic logic [xlen-1:0] expected(int w);
        logic [xlen-1:0] v;
        v = model_mem[w];
        foreach (sq[i]) begin
            if (sq[i].addr[xlen-1:2] == w)
                v = apply_store(v, sq[i]);  // Program order, youngest last
        end
        return v;
    endfunction

    // Free ROB index, none shared with a queued store
    function automatic logic [rob_idx_w-1:0] next_rob();
        bit used;
        do begin
            rob_ctr++;
            used = 1'b0;
            foreach (sq[i])
                used |= sq[i].rob_idx == rob_ctr;
        end while (used);
        return rob_ctr;
    endfunction

    task automatic retire();
        while (sq.size() > 0 && cq[0]) begin
            model_mem[sq[0].addr[4:2]] = apply_store(model_mem[sq[0].addr[4:2]], sq[0]);
            sq.pop_front();
            cq.pop_front();
        end
    endtask

    task automatic check(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errs++;
            $display("ERR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic end_test(string name);
        tests++;
        $display("test %-13s %s, %0d errors", name, test_errs == 0 ? "ok" : "bad", test_errs);
        test_errs = 0;
    endtask

    task automatic clear_strobes();
        store_valid = 1'b0;
        complete    = 1'b0;
        exception   = 1'b0;
        load_valid  = 1'b0;
    endtask

    // ROB completes a random uncommitted store
    task automatic drive_commit();
        int open [$];
        int pick;
        foreach (cq[i]) begin
            if (!cq[i])
                open.push_back(i);
        end
        if (open.size() > 0) begin
            pick         = open[rand32() % open.size()];
            complete     = 1'b1;
            complete_idx = sq[pick].rob_idx;
            cq[pick]     = 1'b1;
            retire();
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_strobes();
    endtask

    task automatic do_store(logic [2:0] f3, int w, logic [1:0] off, logic [xlen-1:0] data);
        store_req_t s;
        s.addr    = {w[29:0], off};
        s.data    = data;
        s.funct3  = f3;
        s.rob_idx = next_rob();
        forever begin
            store_valid = 1'b1;
            store       = s;
            #1;                             // Stall is combinational
            if (!store_stall)
                break;
            saw_stall = 1'b1;
            next_cycle();
            drive_commit();                 // Held store needs a slot to drain
        end
        sq.push_back(s);
        cq.push_back(1'b0);
        next_cycle();
    endtask

    task automatic do_flush();
        exception = 1'b1;
        while (cq.size() > 0 && !cq[$]) begin
            sq.pop_back();
            cq.pop_back();
        end
        next_cycle();
    endtask

    task automatic commit_all();
        while (cq.size() > 0) begin
            drive_commit();
            next_cycle();
        end
    endtask

    // lat_mode 1 wants done one cycle after accept, 2 wants a longer wait
    task automatic do_load(int w, string name, int lat_mode);
        logic [xlen-1:0] exp;
        int              lat;
        while (load_busy)
            next_cycle();
        exp        = expected(w);
        load_valid = 1'b1;
        load_addr  = {w[29:0], 2'b00};
        lat        = 0;
        do begin
            next_cycle();
            lat++;
            if (!load_done) begin
                check({name, " busy"}, 1, load_busy);  // Held high until the done pulse
                drive_commit();             // Waiting load needs its store drained
            end
        end while (!load_done);
        check(name, exp, load_data);
        if (lat_mode == 1)
            check({name, " latency"}, 1, lat);
        if (lat_mode == 2)
            check({name, " waited"}, 1, lat > 1);
    endtask

    initial begin
        logic [2:0] f3;
        logic [1:0] off;
        int         r;
        int         w;
        int         asrt;
        clear_strobes();
        store        = '0;
        complete_idx = '0;
        load_addr    = '0;
        rob_ctr      = '0;
        saw_stall    = 1'b0;
        reset        = 1'b1;
        foreach (model_mem[i])
            model_mem[i] = '0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < n_words; i++)
            do_store(f3_sw, i, 2'b00, '0);  // Memory is not reset, give it known words
        commit_all();
        repeat (sb_size + 2) next_cycle();

        do_store(f3_sw, 1, 2'b00, rand32());
        do_load(1, "fwd_word", 1);
        commit_all();
        end_test("fwd_word");

        do_store(f3_sb, 2, 2'd1, rand32());
        do_store(f3_sh, 2, 2'd2, rand32());
        do_store(f3_sb, 2, 2'd0, rand32());
        commit_all();
        repeat (sb_size + 2) next_cycle();
        do_load(2, "byte_merge", 0);
        end_test("byte_merge");

        do_store(f3_sw, 3, 2'b00, rand32());
        do_store(f3_sh, 3, 2'd0, rand32());
        do_load(3, "partial_wait", 2);
        commit_all();
        end_test("partial_wait");

        repeat (sb_size + 2) next_cycle();
        saw_stall = 1'b0;                   // Only stalls of this fill count
        for (int i = 0; i <= sb_size; i++)
            do_store(f3_sw, (i + 4) % n_words, 2'b00, rand32()); // Last one overflows
        check("fill stall", 1, saw_stall);
        commit_all();
        for (int i = 0; i <= sb_size; i++)
            do_load((i + 4) % n_words, "fill", 0);
        end_test("fill");

        do_store(f3_sw, 5, 2'b00, rand32());
        commit_all();
        do_store(f3_sw, 5, 2'b00, rand32());
        do_store(f3_sb, 6, 2'd3, rand32());
        do_flush();
        do_load(5, "flush", 0);
        do_load(6, "flush", 0);
        end_test("flush");

        for (int n = 0; n < n_random; n++) begin
            r = int'(rand32() % 16);
            w = int'(rand32() % n_words);
            if (r < 6) begin
                f3  = (r < 2) ? f3_sb : (r < 4) ? f3_sh : f3_sw;
                off = 2'(rand32());
                if (f3 == f3_sh)
                    off[0] = 1'b0;
                if (f3 == f3_sw)
                    off = 2'b00;
                do_store(f3, w, off, rand32());
            end else if (r < 10) begin
                drive_commit();
                next_cycle();
            end else if (r == 10) begin
                do_flush();
            end else if (r < 15) begin
                do_load(w, "random", 0);
            end else begin
                next_cycle();
            end
        end
        end_test("random");

        asrt = lsu_top_i.store_buffer_i.lsu_properties_i.fail_cnt;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, asrt);
        if (errors == 0 && asrt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem import lsu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic            clk,
    input  mem_req_t        mem_req,
    output logic [xlen-1:0] rdata
);

    localparam int aw = $clog2(mem_words);

    logic [xlen-1:0] mem [mem_words];
    logic [aw-1:0]   idx;
    mem_word_u       cur;
    mem_word_u       wr;
    mem_word_u       merged;

    assign idx = mem_req.addr[aw-1:0];        // Upper address bits ignored

    // Byte lane merge of old and new word
    always_comb begin
        cur.word = mem[idx];
        wr.word  = mem_req.wdata;
        merged   = cur;
        for (int b = 0; b < xlen/8; b++) begin
            if (mem_req.be[b])
                merged.bytes[b] = wr.bytes[b];
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.we)
                mem[idx] <= merged.word;
            else
                rdata <= mem[idx];            // Held until the next read
        end
    end

endmodule

`default_nettype wire

// File: verilog/load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit import lsu_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_valid,
    input  logic [xlen-1:0]    load_addr,
    output logic [waddr_w-1:0] query_addr,
    input  load_query_t        query,
    output mem_req_t           rd_req,
    input  logic               rd_gnt,
    input  logic [xlen-1:0]    rdata,
    output logic               load_busy,
    output logic               load_done,
    output logic [xlen-1:0]    load_data
);

    typedef enum logic [1:0] {
        s_idle,
        s_query,                              // Waiting on a partial store or the port
        s_read_wait                           // Memory data returns this cycle
    } state_t;

    state_t             state_q;
    state_t             state_d;
    logic [waddr_w-1:0] addr_q;
    logic               fwd_done_q;
    logic [xlen-1:0]    fwd_data_q;
    logic               take;                 // Load accepted this cycle
    logic               searching;            // Buffer answer acted on this cycle

    assign take       = state_q == s_idle && load_valid;
    assign searching  = take || state_q == s_query;
    assign query_addr = take ? load_addr[xlen-1:2] : addr_q;  // Query in the accept cycle
    assign load_busy  = state_q != s_idle;
    assign load_done  = fwd_done_q || state_q == s_read_wait;
    assign load_data  = (state_q == s_read_wait) ? rdata : fwd_data_q;

    always_comb begin
        rd_req      = '0;
        rd_req.en   = searching && !query.hit && !query.must_wait; // Miss goes to memory
        rd_req.addr = query_addr;
        state_d     = state_q;
        if (searching) begin
            if (query.hit)
                state_d = s_idle;
            else if (rd_gnt)
                state_d = s_read_wait;
            else
                state_d = s_query;            // Retry next cycle
        end else if (state_q == s_read_wait) begin
            state_d = s_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= s_idle;
            fwd_done_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            fwd_done_q <= searching && query.hit;
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            addr_q <= query_addr;
        if (searching && query.hit)
            fwd_data_q <= query.data;         // Forwarded word
    end

endmodule

`default_nettype wire

// File: verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int xlen      = 32;
    localparam int rob_idx_w = 4;
    localparam int waddr_w   = xlen - 2;   // Word address, byte offset dropped

    // funct3 of the store instructions
    localparam logic [2:0] f3_sb = 3'b000;
    localparam logic [2:0] f3_sh = 3'b001;
    localparam logic [2:0] f3_sw = 3'b010;

    // Store as it leaves issue
    typedef struct packed {
        logic [xlen-1:0]      addr;
        logic [xlen-1:0]      data;     // Right aligned, lanes picked at drain
        logic [2:0]           funct3;
        logic [rob_idx_w-1:0] rob_idx;
    } store_req_t;

    // One access on the shared memory port
    typedef struct packed {
        logic               en;
        logic               we;
        logic [waddr_w-1:0] addr;
        logic [xlen-1:0]    wdata;    // Already shifted into its byte lanes
        logic [xlen/8-1:0]  be;
    } mem_req_t;

    // Store buffer answer for one word address
    typedef struct packed {
        logic            hit;         // Youngest match is a full word
        logic            must_wait;   // Youngest match is sb or sh
        logic [xlen-1:0] data;
    } load_query_t;

    // Same word, seen whole or by byte lane
    typedef union packed {
        logic [xlen-1:0]        word;
        logic [xlen/8-1:0][7:0] bytes;
    } mem_word_u;

endpackage

`default_nettype wire

// File: verilog/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; #(
    parameter int sb_size   = 4,
    parameter int mem_words = 256
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 store_valid,
    input  store_req_t           store,
    output logic                 store_stall,
    input  logic                 complete,
    input  logic [rob_idx_w-1:0] complete_idx,
    input  logic                 exception,
    input  logic                 load_valid,
    input  logic [xlen-1:0]      load_addr,
    output logic                 load_busy,
    output logic                 load_done,
    output logic [xlen-1:0]      load_data
);

    logic [waddr_w-1:0] query_addr;           // Load word address into the buffer
    load_query_t        query;
    mem_req_t           drain_req;
    mem_req_t           rd_req;
    mem_req_t           mem_req;
    logic               drain_gnt;
    logic               rd_gnt;
    logic               full;
    logic [xlen-1:0]    rdata;

    store_buffer #(.sb_size(sb_size)) store_buffer_i (
        .clk, .reset,
        .store_valid, .store,
        .complete, .complete_idx, .exception,
        .query_addr, .query,
        .drain_req, .drain_gnt,
        .full, .store_stall
    );

    load_unit load_unit_i (
        .clk, .reset,
        .load_valid, .load_addr,
        .query_addr, .query,
        .rd_req, .rd_gnt, .rdata,
        .load_busy, .load_done, .load_data
    );

    mem_arbiter mem_arbiter_i (
        .clk, .reset,
        .rd_req, .drain_req, .full,
        .rd_gnt, .drain_gnt,
        .mem_req
    );

    data_mem #(.mem_words(mem_words)) data_mem_i (
        .clk,
        .mem_req,
        .rdata
    );

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t rd_req,
    input  mem_req_t drain_req,
    input  logic     full,
    output logic     rd_gnt,
    output logic     drain_gnt,
    output mem_req_t mem_req
);

    logic rd_pending_q;                       // Read granted last cycle, data due now

    // Reads first, but a full buffer drains ahead of them
    assign drain_gnt = drain_req.en && (full || (!rd_req.en && !rd_pending_q));
    assign rd_gnt    = rd_req.en && !drain_gnt;

    always_comb begin
        if (drain_gnt)
            mem_req = drain_req;
        else if (rd_gnt)
            mem_req = rd_req;
        else
            mem_req = '0;                     // Port idle
    end

    // Keeps a drain one cycle clear of a read's data return
    always_ff @(posedge clk) begin
        if (reset)
            rd_pending_q <= 1'b0;
        else
            rd_pending_q <= rd_gnt;
    end

endmodule

`default_nettype wire

// File: verilog/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module store_buffer import lsu_pkg::*; #(
    parameter int sb_size = 4             // Power of two
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 store_valid,
    input  store_req_t           store,
    input  logic                 complete,
    input  logic [rob_idx_w-1:0] complete_idx,
    input  logic                 exception,
    input  logic [waddr_w-1:0]   query_addr,
    output load_query_t          query,
    output mem_req_t             drain_req,
    input  logic                 drain_gnt,
    output logic                 full,
    output logic                 store_stall
);

    localparam int ptr_w = $clog2(sb_size);

    store_req_t         entries [sb_size];
    logic [sb_size-1:0] committed_q;       // ROB has retired this entry
    logic [ptr_w:0]     head_q;            // Oldest entry, msb is the wrap bit
    logic [ptr_w:0]     tail_q;            // Next free slot
    logic [ptr_w:0]     count;
    logic [ptr_w:0]     keep_cnt;          // Entries surviving a flush
    logic [sb_size-1:0] live;              // Slot lies between head and tail
    logic               push;
    logic               pop;
    store_req_t         oldest;
    mem_word_u          lane_data;

    assign count       = tail_q - head_q;
    assign full        = count == (ptr_w+1)'(sb_size);
    assign store_stall = store_valid && full;              // Dropped, source retries
    assign push        = store_valid && !full && !exception; // Squashed with the flush
    assign pop         = drain_req.en && drain_gnt;
    assign oldest      = entries[head_q[ptr_w-1:0]];

    // Slot is live when its distance from head is below the count
    always_comb begin
        logic [ptr_w-1:0] age;
        for (int i = 0; i < sb_size; i++) begin
            age     = ptr_w'(i) - head_q[ptr_w-1:0];
            live[i] = {1'b0, age} < count;
        end
    end

    // Walk oldest to youngest so the last match found is the youngest
    always_comb begin
        logic [ptr_w-1:0] idx;
        query    = '0;
        keep_cnt = '0;
        for (int a = 0; a < sb_size; a++) begin
            idx = head_q[ptr_w-1:0] + ptr_w'(a);
            if (live[idx] && committed_q[idx])
                keep_cnt = (ptr_w+1)'(a + 1);              // Just past youngest committed
            if (live[idx] && entries[idx].addr[xlen-1:2] == query_addr) begin
                query.hit       = entries[idx].funct3 == f3_sw;
                query.must_wait = entries[idx].funct3 != f3_sw; // Partial, let it drain
                query.data      = entries[idx].data;
            end
        end
    end

    // Drain request for the head entry, data moved onto its lanes
    always_comb begin
        lane_data.word = '0;
        drain_req      = '0;
        case (oldest.funct3)
            f3_sb: begin
                lane_data.bytes[oldest.addr[1:0]] = oldest.data[7:0];
                drain_req.be[oldest.addr[1:0]]    = 1'b1;
            end
            f3_sh: begin
                lane_data.bytes[{oldest.addr[1], 1'b0}] = oldest.data[7:0];
                lane_data.bytes[{oldest.addr[1], 1'b1}] = oldest.data[15:8];
                drain_req.be[{oldest.addr[1], 1'b0} +: 2] = 2'b11;
            end
            default: begin
                lane_data.word = oldest.data;             // sw, all lanes
                drain_req.be   = '1;
            end
        endcase
        drain_req.en    = count != '0 && committed_q[head_q[ptr_w-1:0]];
        drain_req.we    = 1'b1;
        drain_req.addr  = oldest.addr[xlen-1:2];
        drain_req.wdata = lane_data.word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q      <= '0;
            tail_q      <= '0;
            committed_q <= '0;
        end else begin
            if (pop) begin
                head_q                         <= head_q + 1'b1;
                committed_q[head_q[ptr_w-1:0]] <= 1'b0;
            end
            if (complete) begin
                for (int i = 0; i < sb_size; i++) begin
                    if (live[i] && !committed_q[i] && entries[i].rob_idx == complete_idx)
                        committed_q[i] <= 1'b1;           // Drain may start next cycle
                end
            end
            if (exception) begin
                tail_q <= head_q + keep_cnt;              // Committed stores stay
            end else if (push) begin
                tail_q                         <= tail_q + 1'b1;
                committed_q[tail_q[ptr_w-1:0]] <= 1'b0;   // Clear any stale mark
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            entries[tail_q[ptr_w-1:0]] <= store;
    end

endmodule

`default_nettype wire
